// File: logic/mem_pkg.sv
// Memory-side definitions shared by the SRAM, the arbiter and the APB loading port
`default_nettype none

package mem_pkg;

   // Owner of the SRAM access accepted in the previous cycle
   typedef enum logic [1:0] {
      OWN_NONE  = 2'd0,
      OWN_APB   = 2'd1,
      OWN_FETCH = 2'd2
   } mem_owner_t;

   // Byte offset bits inside one 32-bit word
   localparam int unsigned MEM_WORD_BITS = 2;

   // Upper address bits left once the byte offset is dropped
   localparam int unsigned MEM_HI_BITS = 32 - MEM_WORD_BITS;

   // Word index width for a given depth
   // Never below one bit, even for a single-word array
   function automatic int unsigned idx_bits(input int unsigned depth);
      return (depth > 1) ? $clog2(depth) : 1;
   endfunction

endpackage

`default_nettype wire

// File: logic/core_pkg.sv
// Core-side definitions for the fetch pipe, opcode classes and decoded records
`default_nettype none

package core_pkg;

   // Fetch to decode payload
   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] ir;
   } pipe_ifid_t;

   // Major opcode classes of RV32I
   typedef enum logic [3:0] {
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
      OP_STORE, OP_IMM, OP_REG, OP_SYSTEM, OP_ILLEGAL
   } op_class_t;

   // Decode output record
   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] ir;
      op_class_t   op;
      logic [31:0] imm;
   } dec_out_t;

   // Full 7-bit opcode match, so bits [1:0] must be 2'b11
   function automatic op_class_t op_classify(input logic [31:0] ir);
      case (ir[6:0])
         7'b0110111: return OP_LUI;
         7'b0010111: return OP_AUIPC;
         7'b1101111: return OP_JAL;
         7'b1100111: return OP_JALR;
         7'b1100011: return OP_BRANCH;
         7'b0000011: return OP_LOAD;
         7'b0100011: return OP_STORE;
         7'b0010011: return OP_IMM;
         7'b0110011: return OP_REG;
         7'b1110011: return OP_SYSTEM;
         default:    return OP_ILLEGAL;
      endcase
   endfunction

   // Sign-extended immediate in the format of the class
   function automatic logic [31:0] op_immediate(input logic [31:0] ir, input op_class_t cls);
      case (cls)
         OP_LUI, OP_AUIPC: return {ir[31:12], 12'b0};
         OP_JAL:           return {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
         OP_BRANCH:        return {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
         OP_STORE:         return {{21{ir[31]}}, ir[30:25], ir[11:7]};
         OP_JALR, OP_LOAD, OP_IMM, OP_SYSTEM:
                           return {{21{ir[31]}}, ir[30:20]};
         // R-type and illegal words carry no immediate
         default:          return 32'h0;
      endcase
   endfunction

endpackage

`default_nettype wire

// File: logic/imem_sram.sv
// Single-port word SRAM with a registered read
`timescale 1ns/1ps
`default_nettype none

module imem_sram
   import mem_pkg::*;
#(
   parameter int unsigned DEPTH_WORDS = 256
) (
   input  logic                              clk,
   input  logic                              en,
   input  logic                              we,
   input  logic [idx_bits(DEPTH_WORDS)-1:0]  addr,
   input  logic [31:0]                       wdata,
   output logic [31:0]                       rdata
);

   logic [31:0] mem [DEPTH_WORDS];

   // Read returns the old word on a write cycle
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) mem[addr] <= wdata;
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
// Fixed-priority SRAM arbiter that puts the APB loading port ahead of instruction fetch
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
   import mem_pkg::*;
#(
   parameter int unsigned DEPTH_WORDS = 256
) (
   input  logic                              clk,
   input  logic                              rstz,
   // APB loading port
   input  logic                              apb_req,
   input  logic                              apb_we,
   input  logic [31:0]                       apb_addr,
   input  logic [31:0]                       apb_wdata,
   output logic                              apb_gnt,
   output logic [31:0]                       apb_rdata,
   // Instruction fetch, read only
   input  logic                              if_req,
   input  logic [31:0]                       if_addr,
   output logic                              if_gnt,
   output logic [31:0]                       if_rdata,
   // SRAM side
   output logic                              mem_en,
   output logic                              mem_we,
   output logic [idx_bits(DEPTH_WORDS)-1:0]  mem_addr,
   output logic [31:0]                       mem_wdata,
   input  logic [31:0]                       mem_rdata
);

   localparam int unsigned IW = idx_bits(DEPTH_WORDS);

   mem_owner_t owner;

   // Winner goes to the SRAM this cycle
   assign mem_en    = apb_req || if_req;
   assign mem_we    = apb_req && apb_we;
   assign mem_addr  = apb_req ? apb_addr[MEM_WORD_BITS +: IW] : if_addr[MEM_WORD_BITS +: IW];
   assign mem_wdata = apb_wdata;

   always_ff @(posedge clk or negedge rstz) begin
      if (!rstz) begin
         owner <= OWN_NONE;
      end else begin
         if (apb_req) owner <= OWN_APB;
         else if (if_req) owner <= OWN_FETCH;
         else owner <= OWN_NONE;
      end
   end

   // Grant and read data a cycle after acceptance
   assign apb_gnt   = (owner == OWN_APB);
   assign if_gnt    = (owner == OWN_FETCH);
   assign apb_rdata = apb_gnt ? mem_rdata : 32'h0;
   assign if_rdata  = if_gnt ? mem_rdata : 32'h0;

   a_one_gnt : assert property (@(posedge clk) disable iff (!rstz)
      !(apb_gnt && if_gnt));

   // Requesters drop req in their grant cycle
   a_req_drop : assert property (@(posedge clk) disable iff (!rstz)
      !(apb_gnt && apb_req) && !(if_gnt && if_req));

endmodule

`default_nettype wire

// File: logic/apb_mem_port.sv
// APB slave, turns bus transfers into arbitrated SRAM reads and writes
`timescale 1ns/1ps
`default_nettype none

module apb_mem_port
   import mem_pkg::*;
#(
   parameter int unsigned DEPTH_WORDS = 256
) (
   input  logic        clk,
   input  logic        rstz,
   // APB
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   // Towards the arbiter
   output logic        mem_req,
   output logic        mem_we,
   output logic [31:0] mem_addr,
   output logic [31:0] mem_wdata,
   input  logic        mem_gnt,
   input  logic [31:0] mem_rdata
);

   logic access;
   logic out_of_range;
   logic done_q;

   assign access       = psel && penable;
   assign out_of_range = (paddr[31:MEM_WORD_BITS] >= MEM_HI_BITS'(DEPTH_WORDS));

   // Request held through the access phase until the grant
   assign mem_req   = access && !out_of_range && !mem_gnt && !done_q;
   assign mem_we    = pwrite;
   assign mem_addr  = paddr;
   assign mem_wdata = pwdata;

   // Completion a cycle after the grant
   always_ff @(posedge clk or negedge rstz) begin
      if (!rstz) begin
         done_q <= 1'b0;
      end else begin
         done_q <= mem_gnt;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_gnt && !pwrite) prdata <= mem_rdata;
   end

   // Bad address ends in the first access cycle without touching memory
   assign pslverr = access && out_of_range;
   assign pready  = done_q || pslverr;

   a_apb_hold : assert property (@(posedge clk) disable iff (!rstz)
      (access && !pready) |=> ($stable(paddr) && $stable(pwrite)));

endmodule

`default_nettype wire

// File: logic/fetch_lite.sv
// Two-cycle fetch stage, one word per memory grant, with a branch redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_lite
   import core_pkg::*;
#(
   parameter logic [31:0] PC_START = 32'h0
) (
   input  logic        clk,
   input  logic        rstz,
   input  logic        run,
   // Instruction memory side
   output logic [31:0] instr_addr,
   input  logic [31:0] instr_data,
   output logic        instr_req,
   input  logic        instr_gnt,
   // Towards decode
   output pipe_ifid_t  pipe_ifid,
   output logic        pipe_vld,
   input  logic        pipe_rdy,
   // Redirect from decode
   input  logic [31:0] branch_target,
   input  logic        branch
);

   logic [31:0] pc;
   logic        fetch_vld;

   // PC and slot state
   // The grant comes a cycle after acceptance, so pc still names the granted word
   always_ff @(posedge clk or negedge rstz) begin
      if (!rstz) begin
         pc        <= PC_START;
         fetch_vld <= 1'b0;
      end else begin
         if (instr_gnt) begin
            pc        <= branch ? branch_target : (pc + 32'd4);
            fetch_vld <= 1'b1;
         end else if (fetch_vld && pipe_rdy) begin
            fetch_vld <= 1'b0;
         end
      end
   end

   // Captured word
   always_ff @(posedge clk) begin
      if (instr_gnt) begin
         pipe_ifid.pc <= instr_addr;
         pipe_ifid.ir <= instr_data;
      end
   end

   assign instr_addr = pc;

   // Drop req in the grant cycle; ask only when the slot frees up this cycle
   assign instr_req = run && !instr_gnt && (!fetch_vld || pipe_rdy);

   assign pipe_vld = fetch_vld;

   // Jump targets come from decode, so check alignment at the memory port
   a_instr_aligned : assert property (@(posedge clk) disable iff (!rstz)
      instr_req |-> (instr_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: logic/decode_lite.sv
// Decode stage, classifies words, forms immediates, redirects on JAL, drops wrong path
`timescale 1ns/1ps
`default_nettype none

module decode_lite
   import core_pkg::*;
(
   input  logic        clk,
   input  logic        rstz,
   // From fetch
   input  pipe_ifid_t  pipe_ifid,
   input  logic        pipe_vld,
   output logic        pipe_rdy,
   // Redirect handshake, released by the fetch grant
   input  logic        instr_gnt,
   output logic        branch,
   output logic [31:0] branch_target,
   // Decoded stream
   output dec_out_t    dec,
   output logic        dec_vld,
   input  logic        dec_rdy
);

   typedef enum logic [1:0] {
      IDLE,
      REDIRECT,
      FLUSH
   } dec_state_t;

   dec_state_t  state;
   logic [31:0] target_q;
   op_class_t   cls;
   logic [31:0] imm;
   logic [31:0] jal_target;
   logic        jump;
   logic        on_path;
   logic        keep;

   always_comb begin
      cls        = op_classify(pipe_ifid.ir);
      imm        = op_immediate(pipe_ifid.ir, cls);
      jal_target = pipe_ifid.pc + imm;
      // JAL to the next word needs no redirect
      jump       = (cls == OP_JAL) && (jal_target != (pipe_ifid.pc + 32'd4));
      // After a redirect only the target word resumes the stream
      on_path    = (state == IDLE) || ((state == FLUSH) && (pipe_ifid.pc == target_q));
   end

   // One-deep output slot
   assign pipe_rdy = !dec_vld || dec_rdy;
   assign keep     = pipe_vld && pipe_rdy && on_path;

   always_ff @(posedge clk or negedge rstz) begin
      if (!rstz) begin
         state    <= IDLE;
         target_q <= 32'h0;
         dec_vld  <= 1'b0;
      end else begin
         case (state)
            IDLE, FLUSH: begin
               if (keep) state <= jump ? REDIRECT : IDLE;
            end
            // Fetch picks up the target on its next grant
            REDIRECT: begin
               if (instr_gnt) state <= FLUSH;
            end
            default: state <= IDLE;
         endcase

         if (keep && jump) target_q <= jal_target;

         if (keep) dec_vld <= 1'b1;
         else if (dec_rdy) dec_vld <= 1'b0;
      end
   end

   // Output record
   always_ff @(posedge clk) begin
      if (keep) begin
         dec.pc  <= pipe_ifid.pc;
         dec.ir  <= pipe_ifid.ir;
         dec.op  <= cls;
         dec.imm <= imm;
      end
   end

   assign branch        = (state == REDIRECT);
   assign branch_target = target_q;

   // Stalled record holds
   a_dec_stable : assert property (@(posedge clk) disable iff (!rstz)
      (dec_vld && !dec_rdy) |=> (dec_vld && $stable(dec)));

endmodule

`default_nettype wire

// File: logic/fetch_sys_top.sv
// Instruction front end top, fetch and decode sharing one SRAM with an APB loader
`timescale 1ns/1ps
`default_nettype none

module fetch_sys_top
   import core_pkg::*, mem_pkg::*;
#(
   parameter int unsigned DEPTH_WORDS = 256,
   parameter logic [31:0] PC_START    = 32'h0
) (
   input  logic        clk,
   input  logic        rstz,
   input  logic        run,
   // APB loading port
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   // Decoded stream
   output dec_out_t    dec,
   output logic        dec_vld,
   input  logic        dec_rdy
);

   localparam int unsigned IW = idx_bits(DEPTH_WORDS);

   // Fetch side
   logic [31:0] instr_addr;
   logic [31:0] instr_data;
   logic        instr_req;
   logic        instr_gnt;
   pipe_ifid_t  pipe_ifid;
   logic        pipe_vld;
   logic        pipe_rdy;
   logic [31:0] branch_target;
   logic        branch;

   // APB port to arbiter
   logic        apb_req;
   logic        apb_we;
   logic [31:0] apb_addr;
   logic [31:0] apb_wdata;
   logic        apb_gnt;
   logic [31:0] apb_rdata;

   // Arbiter to SRAM
   logic          mem_en;
   logic          mem_we;
   logic [IW-1:0] mem_addr;
   logic [31:0]   mem_wdata;
   logic [31:0]   mem_rdata;

   fetch_lite #(.PC_START(PC_START)) fetch_i (
      .clk, .rstz, .run,
      .instr_addr, .instr_data, .instr_req, .instr_gnt,
      .pipe_ifid, .pipe_vld, .pipe_rdy,
      .branch_target, .branch
   );

   decode_lite decode_i (
      .clk, .rstz,
      .pipe_ifid, .pipe_vld, .pipe_rdy,
      .instr_gnt, .branch, .branch_target,
      .dec, .dec_vld, .dec_rdy
   );

   apb_mem_port #(.DEPTH_WORDS(DEPTH_WORDS)) apb_i (
      .clk, .rstz,
      .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
      .mem_req(apb_req), .mem_we(apb_we), .mem_addr(apb_addr),
      .mem_wdata(apb_wdata), .mem_gnt(apb_gnt), .mem_rdata(apb_rdata)
   );

   mem_arbiter #(.DEPTH_WORDS(DEPTH_WORDS)) arb_i (
      .clk, .rstz,
      .apb_req, .apb_we, .apb_addr, .apb_wdata, .apb_gnt, .apb_rdata,
      .if_req(instr_req), .if_addr(instr_addr), .if_gnt(instr_gnt), .if_rdata(instr_data),
      .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
   );

   imem_sram #(.DEPTH_WORDS(DEPTH_WORDS)) sram_i (
      .clk,
      .en(mem_en), .we(mem_we), .addr(mem_addr),
      .wdata(mem_wdata), .rdata(mem_rdata)
   );

endmodule

`default_nettype wire

// File: testbench/tb_fetch_sys.sv
// Testbench for the instruction front end that loads programs over APB and checks the decoded stream
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_sys
   import core_pkg::*;
();

   localparam int          DEPTH_WORDS = 256;
   localparam logic [31:0] PC_START    = 32'h0000_0040;
   localparam int          CLK_PERIOD  = 8;
   localparam int          PROG_MAX    = 32;
   localparam int          APB_CYC     = 6;
   localparam int          APB_LIMIT   = 16;
   localparam int          STALL_LIMIT = 32;
   // Reset, program load and stream drain for one program test
   localparam int          PROG_CYC    = PROG_MAX * APB_CYC + 4 * PROG_MAX + 8;
   localparam int          TEST_CYC    = 2 * DEPTH_WORDS * APB_CYC + 5 * APB_CYC
                                         + 4 * PROG_CYC + 12 * (APB_CYC + 3);
   localparam int          WATCHDOG_NS = 4 * TEST_CYC * CLK_PERIOD;

   logic        clk;
   logic        rstz;
   logic        run;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   dec_out_t    dec;
   logic        dec_vld;
   logic        dec_rdy;

   int          seed = 32'hc2e6;
   int          errors = 0;
   // Shadow copy of the SRAM and the program under test
   logic [31:0] shadow [DEPTH_WORDS];
   logic [31:0] prog_ir [PROG_MAX];
   op_class_t   prog_cls [PROG_MAX];
   logic [31:0] prog_imm [PROG_MAX];
   int          prog_n = 0;
   dec_out_t    exp_q [$];

   fetch_sys_top #(.DEPTH_WORDS(DEPTH_WORDS), .PC_START(PC_START)) dut_i (
      .clk, .rstz, .run,
      .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
      .dec, .dec_vld, .dec_rdy
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(WATCHDOG_NS);
      $display("** Error: simulation ran past the watchdog limit");
      $display("Some tests failed");
      $fatal(1, "watchdog expired");
   end

   task automatic check_val(input string name, input logic [31:0] want, input logic [31:0] got);
      if (got !== want) begin
         errors++;
         $display("** Error: %s expected %h got %h", name, want, got);
         $display("Some tests failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic fail_run(input string what);
      $display("** Error: %s", what);
      $display("Some tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   // Instruction encoders that place the chosen immediate
   function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [31:0] imm);
      return {imm[11:0], 5'd1, 3'd0, 5'd2, op};
   endfunction

   function automatic logic [31:0] enc_s(input logic [31:0] imm);
      return {imm[11:5], 5'd2, 5'd1, 3'd2, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(input logic [31:0] imm);
      return {imm[12], imm[10:5], 5'd2, 5'd1, 3'd1, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [31:0] imm);
      return {imm[31:12], 5'd3, op};
   endfunction

   function automatic logic [31:0] enc_j(input logic [31:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
   endfunction

   task automatic put_word(input logic [31:0] ir, input op_class_t cls, input logic [31:0] imm);
      if (prog_n >= PROG_MAX) begin
         fail_run("test program is longer than the program buffer");
      end else begin
         prog_ir[prog_n]  = ir;
         prog_cls[prog_n] = cls;
         prog_imm[prog_n] = imm;
         prog_n++;
      end
   endtask

   // One APB transfer with setup and then access until pready
   task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int waited;
      int want_wait;
      waited    = 0;
      // Two cycles after the first access cycle, or at once for a bad address
      want_wait = ((addr >> 2) >= DEPTH_WORDS) ? 0 : 2;
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      while (!pready) begin
         waited++;
         if (waited > APB_LIMIT) begin
            fail_run("APB transfer never completed with pready");
         end else begin
            @(negedge clk);
         end
      end
      rdata = prdata;
      err   = pslverr;
      check_val("pready wait cycles", 32'(want_wait), 32'(waited));
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
      logic [31:0] unused_rd;
      apb_xfer(1'b1, addr, data, unused_rd, err);
      if (!err) shadow[int'(addr >> 2)] = data;
   endtask

   task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
      apb_xfer(1'b0, addr, 32'h0, data, err);
   endtask

   // Two-cycle reset pulse with output checks while held
   task automatic dut_reset();
      @(posedge clk);
      #1;
      rstz    = 1'b0;
      run     = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      dec_rdy = 1'b1;
      @(negedge clk);
      check_val("dec_vld", 32'h0, {31'h0, dec_vld});
      check_val("pready", 32'h0, {31'h0, pready});
      check_val("instr_req", 32'h0, {31'h0, dut_i.instr_req});
      check_val("instr_gnt", 32'h0, {31'h0, dut_i.instr_gnt});
      check_val("apb_gnt", 32'h0, {31'h0, dut_i.apb_gnt});
      check_val("branch", 32'h0, {31'h0, dut_i.branch});
      repeat (2) @(posedge clk);
      #1;
      rstz = 1'b1;
   endtask

   task automatic load_program();
      logic err;
      for (int i = 0; i < prog_n; i++) begin
         apb_write(PC_START + 32'(i * 4), prog_ir[i], err);
         check_val("pslverr", 32'h0, {31'h0, err});
      end
   endtask

   // Program order walk where JAL moves the pc by its immediate
   task automatic build_model();
      logic [31:0] pc;
      int          idx;
      dec_out_t    rec;
      exp_q.delete();
      pc  = PC_START;
      idx = 0;
      while (idx >= 0 && idx < prog_n && exp_q.size() < PROG_MAX) begin
         rec.pc  = pc;
         rec.ir  = prog_ir[idx];
         rec.op  = prog_cls[idx];
         rec.imm = prog_imm[idx];
         exp_q.push_back(rec);
         if (prog_cls[idx] == OP_JAL) pc = pc + prog_imm[idx];
         else pc = pc + 32'd4;
         idx = int'((pc - PC_START) >> 2);
      end
   endtask

   // Raises run and checks each accepted record against the model queue
   task automatic collect_stream(input logic rand_rdy, output int first_vld);
      dec_out_t    want;
      logic [31:0] rnd;
      int          cyc;
      int          idle;
      cyc       = 0;
      idle      = 0;
      first_vld = -1;
      @(posedge clk);
      #1;
      run = 1'b1;
      while (exp_q.size() > 0) begin
         @(negedge clk);
         if (dec_vld && first_vld < 0) first_vld = cyc;
         if (dec_vld && dec_rdy) begin
            want = exp_q.pop_front();
            check_val("dec.pc", want.pc, dec.pc);
            check_val("dec.ir", want.ir, dec.ir);
            check_val("dec.op", {28'h0, want.op}, {28'h0, dec.op});
            check_val("dec.imm", want.imm, dec.imm);
            idle = 0;
         end else if (!dec_vld) begin
            idle++;
         end
         if (idle > STALL_LIMIT) fail_run("decoded stream stopped before the program ended");
         @(posedge clk);
         #1;
         cyc++;
         if (rand_rdy) begin
            rnd     = $random(seed);
            dec_rdy = rnd[0];
         end
      end
      dec_rdy = 1'b1;
   endtask

   // Random fill of the whole SRAM and read back
   task automatic apb_rw_sweep();
      logic [31:0] rnd;
      logic [31:0] data;
      logic        err;
      for (int i = 0; i < DEPTH_WORDS; i++) begin
         rnd = $random(seed);
         apb_write(32'(i * 4), rnd, err);
         check_val("pslverr", 32'h0, {31'h0, err});
      end
      for (int i = 0; i < DEPTH_WORDS; i++) begin
         apb_read(32'(i * 4), data, err);
         check_val("pslverr", 32'h0, {31'h0, err});
         check_val("prdata", shadow[i], data);
      end
   endtask

   task automatic apb_range_error();
      logic [31:0] data;
      logic        err;
      apb_write(32'(DEPTH_WORDS * 4), 32'hdead_beef, err);
      check_val("pslverr", 32'h1, {31'h0, err});
      apb_write(32'hffff_fffc, 32'h1234_5678, err);
      check_val("pslverr", 32'h1, {31'h0, err});
      apb_read(32'(DEPTH_WORDS * 4 + 8), data, err);
      check_val("pslverr", 32'h1, {31'h0, err});
      // Word indices that the rejected addresses would alias onto
      apb_read(32'h0, data, err);
      check_val("pslverr", 32'h0, {31'h0, err});
      check_val("prdata", shadow[0], data);
      apb_read(32'((DEPTH_WORDS - 1) * 4), data, err);
      check_val("pslverr", 32'h0, {31'h0, err});
      check_val("prdata", shadow[DEPTH_WORDS - 1], data);
   endtask

   task automatic all_classes_run();
      int first_vld;
      prog_n = 0;
      put_word(enc_i(7'b0010011, 32'hffff_ffec), OP_IMM, 32'hffff_ffec);
      put_word(enc_u(7'b0110111, 32'hdead_b000), OP_LUI, 32'hdead_b000);
      put_word(enc_u(7'b0010111, 32'h0001_2000), OP_AUIPC, 32'h0001_2000);
      put_word(enc_i(7'b0000011, 32'h0000_0010), OP_LOAD, 32'h0000_0010);
      put_word(enc_s(32'hffff_ffe4), OP_STORE, 32'hffff_ffe4);
      put_word({7'b0100000, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0110011}, OP_REG, 32'h0);
      put_word(enc_b(32'hffff_fa5e), OP_BRANCH, 32'hffff_fa5e);
      put_word(enc_i(7'b1100111, 32'hffff_fff8), OP_JALR, 32'hffff_fff8);
      // Jump to the next word keeps the stream sequential
      put_word(enc_j(32'h0000_0004), OP_JAL, 32'h0000_0004);
      put_word(enc_i(7'b1110011, 32'h0000_0305), OP_SYSTEM, 32'h0000_0305);
      put_word(32'h0000_0000, OP_ILLEGAL, 32'h0);
      put_word(32'hffff_ffff, OP_ILLEGAL, 32'h0);
      put_word(enc_i(7'b0010011, 32'h0000_07ff), OP_IMM, 32'h0000_07ff);
      dut_reset();
      load_program();
      build_model();
      collect_stream(1'b0, first_vld);
      // Idle SRAM gives the first record three cycles after run
      check_val("first dec_vld cycle", 32'd3, 32'(first_vld));
   endtask

   task automatic jal_redirect_run();
      int first_vld;
      prog_n = 0;
      put_word(enc_i(7'b0010011, 32'h0000_0001), OP_IMM, 32'h0000_0001);
      put_word(enc_j(32'h0000_0010), OP_JAL, 32'h0000_0010);
      put_word(enc_u(7'b0110111, 32'h0bad_0000), OP_LUI, 32'h0bad_0000);
      put_word(enc_i(7'b0010011, 32'hffff_fbad), OP_IMM, 32'hffff_fbad);
      // Reached only from the backward jump
      put_word(enc_j(32'h0000_001c), OP_JAL, 32'h0000_001c);
      put_word(enc_i(7'b0010011, 32'h0000_0005), OP_IMM, 32'h0000_0005);
      put_word(enc_j(32'h0000_000c), OP_JAL, 32'h0000_000c);
      put_word(enc_s(32'h0000_00ad), OP_STORE, 32'h0000_00ad);
      put_word({7'b0000000, 5'd2, 5'd1, 3'd6, 5'd3, 7'b0110011}, OP_REG, 32'h0);
      put_word(enc_j(32'hffff_ffec), OP_JAL, 32'hffff_ffec);
      put_word(enc_i(7'b0010011, 32'hffff_fbad), OP_IMM, 32'hffff_fbad);
      put_word(enc_i(7'b0010011, 32'h0000_000b), OP_IMM, 32'h0000_000b);
      put_word(enc_u(7'b0110111, 32'h1234_5000), OP_LUI, 32'h1234_5000);
      dut_reset();
      load_program();
      build_model();
      collect_stream(1'b0, first_vld);
   endtask

   task automatic random_stall_run();
      logic [31:0] rnd;
      logic [31:0] imm;
      int          first_vld;
      prog_n = 0;
      for (int i = 0; i < 24; i++) begin
         rnd = $random(seed);
         imm = {{20{rnd[11]}}, rnd[11:0]};
         if (i == 9) put_word(enc_j(32'h0000_000c), OP_JAL, 32'h0000_000c);
         else put_word(enc_i(7'b0010011, imm), OP_IMM, imm);
      end
      dut_reset();
      load_program();
      build_model();
      collect_stream(1'b1, first_vld);
   endtask

   // Stall run program again with APB reads competing for the SRAM
   task automatic apb_reads_during_run();
      logic [31:0] rnd;
      logic [31:0] data;
      logic        err;
      int          idx;
      int          first_vld;
      dut_reset();
      build_model();
      fork
         collect_stream(1'b0, first_vld);
         begin
            repeat (12) begin
               rnd = $random(seed);
               idx = int'(rnd[15:0]) % DEPTH_WORDS;
               apb_read(32'(idx * 4), data, err);
               check_val("pslverr", 32'h0, {31'h0, err});
               check_val("prdata", shadow[idx], data);
               repeat (rnd[17:16]) @(posedge clk);
            end
         end
      join
   endtask

   initial begin
      rstz    = 1'b0;
      run     = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = 32'h0;
      pwdata  = 32'h0;
      dec_rdy = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rstz = 1'b1;
      apb_rw_sweep();
      apb_range_error();
      all_classes_run();
      jal_redirect_run();
      random_stall_run();
      apb_reads_during_run();
      if (errors == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("Some tests failed");
         $fatal(1, "errors were counted");
      end
   end

endmodule

`default_nettype wire

// File: fetch_sys.f
logic/mem_pkg.sv
logic/core_pkg.sv
logic/imem_sram.sv
logic/mem_arbiter.sv
logic/apb_mem_port.sv
logic/fetch_lite.sv
logic/decode_lite.sv
logic/fetch_sys_top.sv
testbench/tb_fetch_sys.sv

// File: Makefile
TOP := tb_fetch_sys

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): fetch_sys.f $(wildcard logic/*.sv testbench/*.sv)
	verilator --binary --timing --assert -j 0 -f fetch_sys.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^All tests passed$$"

lint:
	verilator --lint-only --timing --assert -f fetch_sys.f --top-module $(TOP)
	verilator --lint-only --timing --assert -f fetch_sys.f --top-module fetch_sys_top

clean:
	rm -rf obj_dir
